// File: build.f
source/vga_dac_pkg.sv
source/vga_dac_regs.sv
source/dac_port_ctrl.sv
source/pixel_out.sv
source/vga_dac_top.sv
tests/tb_vga_dac_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the VGA DAC testbench with Verilator and runs it.
# The exit status is 0 only when the simulation prints the pass message.

set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
    --top-module tb_vga_dac_top \
    -f build.f \
    -o sim_vga_dac; then
  echo "Verilator build failed"
  exit 1
fi

if ! output="$(./obj_dir/sim_vga_dac)"; then
  echo "$output"
  echo "Simulation exited with an error"
  exit 1
fi

echo "$output"

if echo "$output" | grep -qx "test passed"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// File: source/dac_port_ctrl.sv
//**************************************************
// AXI4-Lite slave with one write and one read in flight, wstrb ignored
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module dac_port_ctrl (
  input  wire logic                   clk,
  input  wire logic                   arst_n,
  input  wire vga_dac_pkg::axil_req_t axil_req,
  input  wire vga_dac_pkg::dac_data_t read_data,
  output vga_dac_pkg::axil_rsp_t      axil_rsp,
  output logic                        write,
  output vga_dac_pkg::pal_index_t     write_data_register,
  output vga_dac_pkg::rgb_cycle_t     write_data_cycle,
  output vga_dac_pkg::dac_data_t      write_data,
  output vga_dac_pkg::pal_index_t     read_data_register,
  output vga_dac_pkg::rgb_cycle_t     read_data_cycle,
  output vga_dac_pkg::pal_index_t     pel_mask
);

  import vga_dac_pkg::*;

  logic       awready_r;
  logic       bvalid_r;
  logic [1:0] bresp_r;
  logic       arready_r;
  logic       rvalid_r;
  logic [1:0] rresp_r;
  axil_data_t rdata_r;
  logic       wr_hs;
  logic       rd_hs;
  logic       wr_mapped;
  logic       rd_mapped;
  logic       rd_stage1;
  logic       rd_stage2;
  axil_addr_t rd_addr_r;
  pal_index_t wr_index_r;
  pal_index_t rd_index_r;
  rgb_cycle_t wr_cycle_r;
  rgb_cycle_t rd_cycle_r;

  function automatic rgb_cycle_t next_cycle(input rgb_cycle_t cyc);
    case (cyc)
      cyc_red:   return cyc_green;
      cyc_green: return cyc_blue;
      default:   return cyc_red;
    endcase
  endfunction

  assign wr_hs     = awready_r && axil_req.awvalid && axil_req.wvalid;
  assign rd_hs     = arready_r && axil_req.arvalid;
  assign wr_mapped = axil_req.awaddr inside {reg_write_index, reg_read_index,
                                             reg_data, reg_pel_mask};
  assign rd_mapped = rd_addr_r inside {reg_write_index, reg_read_index,
                                       reg_data, reg_pel_mask};

  // Write channel. Ready pulses once both valids are up and no response waits
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      awready_r <= 1'b0;
      bvalid_r  <= 1'b0;
      bresp_r   <= resp_okay;
    end else begin
      awready_r <= axil_req.awvalid && axil_req.wvalid && !awready_r && !bvalid_r;
      if (wr_hs) begin
        bvalid_r <= 1'b1;
        bresp_r  <= wr_mapped ? resp_okay : resp_slverr;
      end else if (axil_req.bready) begin
        bvalid_r <= 1'b0;
      end
    end
  end

  // Read channel. Stage 1 lets the palette sample, stage 2 captures the mux
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      arready_r <= 1'b0;
      rd_stage1 <= 1'b0;
      rd_stage2 <= 1'b0;
      rvalid_r  <= 1'b0;
      rresp_r   <= resp_okay;
    end else begin
      arready_r <= axil_req.arvalid && !arready_r && !rd_stage1 && !rd_stage2 && !rvalid_r;
      rd_stage1 <= rd_hs;
      rd_stage2 <= rd_stage1;
      if (rd_stage2) begin
        rvalid_r <= 1'b1;
        rresp_r  <= rd_mapped ? resp_okay : resp_slverr;
      end else if (axil_req.rready) begin
        rvalid_r <= 1'b0;
      end
    end
  end

  // Index and cycle sequencers plus the pixel mask
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_index_r <= '0;
      wr_cycle_r <= cyc_red;
      rd_index_r <= '0;
      rd_cycle_r <= cyc_red;
      pel_mask   <= 8'hFF;
    end else begin
      // A DATA read advances once the palette has taken the current channel
      if (rd_stage1 && rd_addr_r == reg_data) begin
        rd_cycle_r <= next_cycle(rd_cycle_r);
        if (rd_cycle_r == cyc_blue) rd_index_r <= rd_index_r + 8'd1;
      end
      // Host writes come last so a new READ_INDEX wins over an advance
      if (wr_hs) begin
        case (axil_req.awaddr)
          reg_write_index: begin
            wr_index_r <= axil_req.wdata[7:0];
            wr_cycle_r <= cyc_red;
          end
          reg_read_index: begin
            rd_index_r <= axil_req.wdata[7:0];
            rd_cycle_r <= cyc_red;
          end
          reg_data: begin
            wr_cycle_r <= next_cycle(wr_cycle_r);
            if (wr_cycle_r == cyc_blue) wr_index_r <= wr_index_r + 8'd1;
          end
          reg_pel_mask: pel_mask <= axil_req.wdata[7:0];
          default:      ;
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      write <= 1'b0;
    end else begin
      write <= wr_hs && axil_req.awaddr == reg_data;
    end
  end

  // Palette write payload follows the strobe by the same cycle
  always_ff @(posedge clk) begin
    if (wr_hs) begin
      write_data_register <= wr_index_r;
      write_data_cycle    <= wr_cycle_r;
      write_data          <= axil_req.wdata[3:0];
    end
    if (rd_hs) rd_addr_r <= axil_req.araddr;
  end

  always_ff @(posedge clk) begin
    if (rd_stage2) begin
      case (rd_addr_r)
        reg_write_index: rdata_r <= {24'd0, wr_index_r};
        reg_read_index:  rdata_r <= {24'd0, rd_index_r};
        reg_data:        rdata_r <= {28'd0, read_data};
        reg_pel_mask:    rdata_r <= {24'd0, pel_mask};
        default:         rdata_r <= '0;
      endcase
    end
  end

  assign read_data_register = rd_index_r;
  assign read_data_cycle    = rd_cycle_r;

  always_comb begin
    axil_rsp.awready = awready_r;
    axil_rsp.wready  = awready_r;
    axil_rsp.bvalid  = bvalid_r;
    axil_rsp.bresp   = bresp_r;
    axil_rsp.arready = arready_r;
    axil_rsp.rvalid  = rvalid_r;
    axil_rsp.rdata   = rdata_r;
    axil_rsp.rresp   = rresp_r;
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);

  a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid);

  // The host sees the same read data for as long as it stalls
  a_rdata_stable: assert property (@(posedge clk) disable iff (!arst_n)
    axil_rsp.rvalid && !axil_req.rready |=> $stable(axil_rsp.rdata));

endmodule

`default_nettype wire

// File: source/pixel_out.sv
//**************************************************
// Pixels arrive already timed and leave two clock edges later
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module pixel_out (
  input  wire logic                    clk,
  input  wire logic                    arst_n,
  input  wire vga_dac_pkg::video_in_t  video_in,
  input  wire vga_dac_pkg::pal_index_t pel_mask,
  input  wire vga_dac_pkg::rgb_t       rgb,
  output vga_dac_pkg::pal_index_t      index,
  output vga_dac_pkg::video_out_t      video_out
);

  import vga_dac_pkg::*;

  logic hsync_d;
  logic vsync_d;
  logic blank_d;

  // The mask goes in front of the palette lookup
  assign index = video_in.index & pel_mask;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hsync_d   <= 1'b0;
      vsync_d   <= 1'b0;
      blank_d   <= 1'b0;
      video_out <= '0;
    end else begin
      // Sync and blank wait one cycle for the palette output
      hsync_d <= video_in.hsync;
      vsync_d <= video_in.vsync;
      blank_d <= video_in.blank;

      video_out.colour <= blank_d ? rgb_t'('0) : rgb;
      video_out.hsync  <= hsync_d;
      video_out.vsync  <= vsync_d;
    end
  end

  // A blanked input pixel comes out black two edges later
  a_blank_black: assert property (@(posedge clk) disable iff (!arst_n)
    video_in.blank |-> ##2 (video_out.colour == '0));

endmodule

`default_nettype wire

// File: source/vga_dac_pkg.sv
//**************************************************
// Fixed DAC programming model with 8-bit index and 4-bit channels
// AXI4-Lite register offsets sit on 32-bit word boundaries
//**************************************************
`default_nettype none

package vga_dac_pkg;

  typedef logic [3:0] dac_data_t;
  typedef logic [7:0] pal_index_t;

  // Channel that the next DATA access touches
  typedef enum logic [1:0] {
    cyc_red   = 2'd0,
    cyc_green = 2'd1,
    cyc_blue  = 2'd2,
    cyc_none  = 2'd3
  } rgb_cycle_t;

  typedef struct packed {
    dac_data_t red;
    dac_data_t green;
    dac_data_t blue;
  } rgb_t;

  typedef struct packed {
    pal_index_t index;
    logic       hsync;
    logic       vsync;
    logic       blank;
  } video_in_t;

  typedef struct packed {
    rgb_t colour;
    logic hsync;
    logic vsync;
  } video_out_t;

  typedef logic [3:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;

  // Everything the host drives
  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    logic [3:0] wstrb;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  // Everything the slave drives
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

  localparam axil_addr_t reg_write_index = 4'h0;
  localparam axil_addr_t reg_read_index  = 4'h4;
  localparam axil_addr_t reg_data        = 4'h8;
  localparam axil_addr_t reg_pel_mask    = 4'hC;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

// File: source/vga_dac_regs.sv
//**************************************************
// Palette RAM has no reset and entries are undefined until written
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module vga_dac_regs (
  input  wire logic                    clk,
  input  wire logic                    write,
  input  wire vga_dac_pkg::pal_index_t write_data_register,
  input  wire vga_dac_pkg::rgb_cycle_t write_data_cycle,
  input  wire vga_dac_pkg::dac_data_t  write_data,
  input  wire vga_dac_pkg::pal_index_t read_data_register,
  input  wire vga_dac_pkg::rgb_cycle_t read_data_cycle,
  input  wire vga_dac_pkg::pal_index_t index,
  output vga_dac_pkg::dac_data_t       read_data,
  output vga_dac_pkg::rgb_t            rgb
);

  import vga_dac_pkg::*;

  // One array per channel so a host write lands in a single channel
  dac_data_t red_mem   [256];
  dac_data_t green_mem [256];
  dac_data_t blue_mem  [256];

  always_ff @(posedge clk) begin
    if (write) begin
      case (write_data_cycle)
        cyc_red:   red_mem[write_data_register]   <= write_data;
        cyc_green: green_mem[write_data_register] <= write_data;
        cyc_blue:  blue_mem[write_data_register]  <= write_data;
        default:   ;
      endcase
    end
  end

  // Host read-back port, the idle channel reads as zero
  always_ff @(posedge clk) begin
    case (read_data_cycle)
      cyc_red:   read_data <= red_mem[read_data_register];
      cyc_green: read_data <= green_mem[read_data_register];
      cyc_blue:  read_data <= blue_mem[read_data_register];
      default:   read_data <= '0;
    endcase
  end

  // Pixel lookup, one cycle of latency
  always_ff @(posedge clk) begin
    rgb.red   <= red_mem[index];
    rgb.green <= green_mem[index];
    rgb.blue  <= blue_mem[index];
  end

  // The controller always names a channel, so a write lands in exactly one array
  a_write_channel: assert property (@(posedge clk)
    write |-> write_data_cycle inside {cyc_red, cyc_green, cyc_blue});

  // Reading back an entry that was just written gives a known value
  a_read_known: assert property (@(posedge clk)
    write ##1 (read_data_register == $past(write_data_register) &&
               read_data_cycle == $past(write_data_cycle)) |=> !$isunknown(read_data));

endmodule

`default_nettype wire

// File: source/vga_dac_top.sv
//**************************************************
// Host and pixel stream share clk with no clock-domain crossing
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module vga_dac_top (
  input  wire logic                   clk,
  input  wire logic                   arst_n,
  input  wire vga_dac_pkg::axil_req_t axil_req,
  input  wire vga_dac_pkg::video_in_t video_in,
  output vga_dac_pkg::axil_rsp_t      axil_rsp,
  output vga_dac_pkg::video_out_t     video_out
);

  import vga_dac_pkg::*;

  logic       write;
  pal_index_t write_data_register;
  rgb_cycle_t write_data_cycle;
  dac_data_t  write_data;
  pal_index_t read_data_register;
  rgb_cycle_t read_data_cycle;
  dac_data_t  read_data;
  pal_index_t pel_mask;
  pal_index_t index;
  rgb_t       rgb;

  dac_port_ctrl ctrl_i (
    .clk                 (clk),
    .arst_n              (arst_n),
    .axil_req            (axil_req),
    .read_data           (read_data),
    .axil_rsp            (axil_rsp),
    .write               (write),
    .write_data_register (write_data_register),
    .write_data_cycle    (write_data_cycle),
    .write_data          (write_data),
    .read_data_register  (read_data_register),
    .read_data_cycle     (read_data_cycle),
    .pel_mask            (pel_mask)
  );

  vga_dac_regs regs_i (
    .clk                 (clk),
    .write               (write),
    .write_data_register (write_data_register),
    .write_data_cycle    (write_data_cycle),
    .write_data          (write_data),
    .read_data_register  (read_data_register),
    .read_data_cycle     (read_data_cycle),
    .index               (index),
    .read_data           (read_data),
    .rgb                 (rgb)
  );

  pixel_out pixel_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .video_in  (video_in),
    .pel_mask  (pel_mask),
    .rgb       (rgb),
    .index     (index),
    .video_out (video_out)
  );

endmodule

`default_nettype wire

// File: tests/tb_vga_dac_top.sv
//**************************************************
// Drives the DAC top level over AXI4-Lite and the pixel port on clk only
// Only entries that the tests wrote are looked up, the rest stay undefined
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_vga_dac_top;

  import vga_dac_pkg::*;

  // About 250 bus accesses of four to six cycles each, far below the limit
  localparam int max_cycles = 20000;

  logic       clk;
  logic       arst_n;
  axil_req_t  req;
  axil_rsp_t  axil_rsp;
  video_in_t  vin;
  video_out_t video_out;

  // Reference palette and the host-side sequencer state
  rgb_t        ref_pal [256];
  pal_index_t  wr_idx;
  pal_index_t  rd_idx;
  int          wr_cyc;
  int          rd_cyc;
  pal_index_t  mask_model;
  video_in_t   pix_in [64];
  logic [31:0] rng_state;
  int          cycle_count;
  int          errors;
  int          checks;
  int          test_errors;
  int          tests_run;
  int          tests_failed;

  vga_dac_top dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .axil_req  (req),
    .video_in  (vin),
    .axil_rsp  (axil_rsp),
    .video_out (video_out)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic note_failure(input string what);
    errors++;
    test_errors++;
    $display("ERROR: %s", what);
  endtask

  task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input axil_data_t got, input axil_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_sync(input string name, input logic [1:0] got, input logic [1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // One write transaction; bready stays low for stall cycles once bvalid is up
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data, input int stall,
                            output logic [1:0] resp);
    logic [1:0] held;
    @(negedge clk);
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.wstrb   = 4'hF;
    @(negedge clk);
    while (!axil_rsp.awready) @(negedge clk);
    if (!axil_rsp.wready) note_failure("wready did not rise together with awready");
    @(negedge clk);
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    while (!axil_rsp.bvalid) @(negedge clk);
    held = axil_rsp.bresp;
    repeat (stall) begin
      @(negedge clk);
      if (!axil_rsp.bvalid || axil_rsp.bresp !== held)
        note_failure("bvalid or bresp changed while bready was held low");
    end
    req.bready = 1'b1;
    @(negedge clk);
    req.bready = 1'b0;
    resp = held;
  endtask

  task automatic axil_read(input axil_addr_t addr, input int stall,
                           output axil_data_t data, output logic [1:0] resp);
    @(negedge clk);
    req.arvalid = 1'b1;
    req.araddr  = addr;
    @(negedge clk);
    while (!axil_rsp.arready) @(negedge clk);
    @(negedge clk);
    req.arvalid = 1'b0;
    while (!axil_rsp.rvalid) @(negedge clk);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    repeat (stall) begin
      @(negedge clk);
      if (!axil_rsp.rvalid || axil_rsp.rdata !== data || axil_rsp.rresp !== resp)
        note_failure("rvalid or rdata changed while rready was held low");
    end
    req.rready = 1'b1;
    @(negedge clk);
    req.rready = 1'b0;
  endtask

  task automatic set_write_index(input pal_index_t idx);
    logic [1:0] resp;
    axil_write(reg_write_index, {24'd0, idx}, 0, resp);
    check_resp("bresp", resp, resp_okay);
    wr_idx = idx;
    wr_cyc = 0;
  endtask

  task automatic set_read_index(input pal_index_t idx);
    logic [1:0] resp;
    axil_write(reg_read_index, {24'd0, idx}, 0, resp);
    check_resp("bresp", resp, resp_okay);
    rd_idx = idx;
    rd_cyc = 0;
  endtask

  task automatic set_mask(input pal_index_t mask);
    logic [1:0] resp;
    axil_write(reg_pel_mask, {24'd0, mask}, 0, resp);
    check_resp("bresp", resp, resp_okay);
    mask_model = mask;
  endtask

  // Red, green, blue, then the index moves on and wraps at 255
  task automatic data_write(input dac_data_t v);
    logic [1:0] resp;
    axil_write(reg_data, {28'd0, v}, 0, resp);
    check_resp("bresp", resp, resp_okay);
    case (wr_cyc)
      0:       ref_pal[wr_idx].red = v;
      1:       ref_pal[wr_idx].green = v;
      default: ref_pal[wr_idx].blue = v;
    endcase
    if (wr_cyc == 2) begin
      wr_cyc = 0;
      wr_idx = wr_idx + 8'd1;
    end else begin
      wr_cyc++;
    end
  endtask

  task automatic data_read_check();
    axil_data_t data;
    logic [1:0] resp;
    dac_data_t  exp;
    axil_read(reg_data, 0, data, resp);
    check_resp("rresp", resp, resp_okay);
    case (rd_cyc)
      0:       exp = ref_pal[rd_idx].red;
      1:       exp = ref_pal[rd_idx].green;
      default: exp = ref_pal[rd_idx].blue;
    endcase
    check_word("rdata", data, {28'd0, exp});
    if (rd_cyc == 2) begin
      rd_cyc = 0;
      rd_idx = rd_idx + 8'd1;
    end else begin
      rd_cyc++;
    end
  endtask

  task automatic read_reg_check(input axil_addr_t addr, input axil_data_t exp);
    axil_data_t data;
    logic [1:0] resp;
    axil_read(addr, 0, data, resp);
    check_resp("rresp", resp, resp_okay);
    check_word("rdata", data, exp);
  endtask

  // Streams pix_in and checks each pixel two falling edges after it was driven
  task automatic run_pixels(input int count);
    video_in_t p;
    rgb_t      exp_col;
    for (int k = 0; k < count + 2; k++) begin
      @(negedge clk);
      if (k >= 2) begin
        p = pix_in[k-2];
        if (p.blank) exp_col = rgb_t'(12'd0);
        else         exp_col = ref_pal[p.index & mask_model];
        check_rgb("video_out.colour", video_out.colour, exp_col);
        check_sync("video_out.hsync_vsync", {video_out.hsync, video_out.vsync},
                   {p.hsync, p.vsync});
      end
      if (k < count) vin = pix_in[k];
      else           vin = '0;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("PASS: %s", name);
    end else begin
      tests_failed++;
      $display("FAIL: %s with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic test_reset_values();
    read_reg_check(reg_pel_mask, 32'h0000_00FF);
    read_reg_check(reg_write_index, 32'h0);
    read_reg_check(reg_read_index, 32'h0);
    finish_test("reset_values");
  endtask

  task automatic test_wrap_fill();
    set_write_index(8'd250);
    for (int k = 0; k < 24; k++) data_write(dac_data_t'(next_random()));
    set_read_index(8'd250);
    for (int k = 0; k < 24; k++) data_read_check();
    read_reg_check(reg_write_index, {24'd0, wr_idx});
    read_reg_check(reg_read_index, {24'd0, rd_idx});
    finish_test("wrap_fill");
  endtask

  task automatic test_pixel_map();
    set_write_index(8'd16);
    for (int k = 0; k < 120; k++) data_write(dac_data_t'(next_random()));
    for (int k = 0; k < 40; k++) begin
      pix_in[k].index = pal_index_t'(32'd16 + (next_random() % 32'd40));
      pix_in[k].hsync = (k % 7 == 0);
      pix_in[k].vsync = (k % 13 == 0);
      pix_in[k].blank = (k % 5 == 4);
    end
    run_pixels(40);
    finish_test("pixel_map");
  endtask

  task automatic test_pel_mask();
    set_write_index(8'h03);
    repeat (3) data_write(dac_data_t'(next_random()));
    set_mask(8'h0F);
    pix_in[0].index = 8'h13;
    pix_in[0].hsync = 1'b1;
    pix_in[0].vsync = 1'b0;
    pix_in[0].blank = 1'b0;
    run_pixels(1);
    set_mask(8'hFF);
    finish_test("pel_mask");
  endtask

  // A lone red write, then a fresh index restarts the triple at red
  task automatic test_partial_triple();
    set_write_index(8'h80);
    repeat (3) data_write(dac_data_t'(next_random()));
    set_write_index(8'h80);
    data_write(dac_data_t'(next_random()));
    set_read_index(8'h80);
    repeat (3) data_read_check();
    set_write_index(8'h80);
    repeat (3) data_write(dac_data_t'(next_random()));
    set_read_index(8'h80);
    repeat (3) data_read_check();
    read_reg_check(reg_write_index, 32'h0000_0081);
    finish_test("partial_triple");
  endtask

  task automatic test_slverr_stall();
    axil_data_t data;
    logic [1:0] resp;
    set_read_index(8'h80);
    axil_write(4'h2, 32'h0000_0005, 0, resp);
    check_resp("bresp", resp, resp_slverr);
    axil_read(4'h6, 0, data, resp);
    check_resp("rresp", resp, resp_slverr);
    repeat (3) data_read_check();
    axil_write(reg_pel_mask, 32'h0000_005A, 5, resp);
    check_resp("bresp", resp, resp_okay);
    mask_model = 8'h5A;
    axil_read(reg_pel_mask, 5, data, resp);
    check_resp("rresp", resp, resp_okay);
    check_word("rdata", data, {24'd0, mask_model});
    read_reg_check(reg_write_index, {24'd0, wr_idx});
    finish_test("slverr_stall");
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: no result after %0d cycles", max_cycles);
    $display("test failed");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    req          = '0;
    vin          = '0;
    rng_state    = 32'hc745;
    wr_idx       = '0;
    rd_idx       = '0;
    wr_cyc       = 0;
    rd_cyc       = 0;
    mask_model   = 8'hFF;
    errors       = 0;
    checks       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (3) @(negedge clk);
    arst_n = 1'b1;

    test_reset_values();
    test_wrap_fill();
    test_pixel_map();
    test_pel_mask();
    test_partial_triple();
    test_slverr_stall();

    $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
